// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_qpix_daq -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_qpix_daq.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module tb_qpix_daq
    import qpix_event_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic                    clk200;
    logic                    counter_reset;
    logic [`QPIX_NUM_CH-1:0] lvds_in;
    logic                    trigger;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`QPIX_ADDR_W-1:0] paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    // reference model state
    logic [`QPIX_TS_W-1:0]   model_ts;
    event_word_t             exp_q [`QPIX_NUM_CH][$];
    logic [`QPIX_NUM_CH-1:0] model_mask;
    int                      model_lost;
    int                      stall_fill;
    logic                    stall_pending;

    // bookkeeping
    integer                  seed;
    int                      errors;
    int                      checks;
    int                      tests_run;
    int                      test_errors;

    qpix_daq_top u_dut (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .lvds_in       (lvds_in),
        .trigger       (trigger),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr)
    );

    // 50 MHz bench clock with a 20 ns period
    initial
    begin
        clk200 = 1'b0;
        forever #10 clk200 = ~clk200;
    end

    // model time base reads 0 in the first cycle out of reset
    always @(posedge clk200)
    begin
        if (counter_reset)
            model_ts <= '0;
        else
            model_ts <= model_ts + 64'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
            errors++;
        end
    endtask

    // closing counts and then the verdict
    task automatic end_run();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t ns while %s", $time, what);
        errors++;
        end_run();
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk200);
        #2;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        int n;
        psel    = 1'b1;
        pwrite  = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwdata  = data;
        step();
        penable = 1'b1;
        // sample once the access phase has settled
        #1;
        n = 0;
        while (!pready && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        if (!pready)
            timeout_fail("waiting for pready on a write");
        else
        begin
            check_value("pslverr", 64'(pslverr), 64'(exp_err));
            // transfer ends on this edge
            step();
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            output logic [31:0] data);
        int n;
        psel    = 1'b1;
        pwrite  = 1'b0;
        penable = 1'b0;
        paddr   = addr;
        step();
        penable = 1'b1;
        // sample once the access phase has settled
        #1;
        n = 0;
        while (!pready && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        data = '0;
        if (!pready)
            timeout_fail("waiting for pready on a read");
        else
        begin
            // prdata is stable through the access phase
            data = prdata;
            check_value("pslverr", 64'(pslverr), 64'(exp_err));
            step();
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic set_mask(input logic [15:0] mask);
        apb_write(`QPIX_REG_CTRL, {mask, 16'h0000}, 1'b0);
        model_mask = mask;
    endtask

    // expected record has the channel on top of the low 60 timestamp bits
    function automatic event_word_t make_record(input int ch, input logic [63:0] stamp);
        event_word_t rec;
        rec.fields.ch = ch[`QPIX_CH_W-1:0];
        rec.fields.ts = stamp[`QPIX_EV_TS_W-1:0];
        return rec;
    endfunction

    function automatic int expected_total();
        int sum;
        sum = 0;
        for (int i = 0; i < `QPIX_NUM_CH; i++)
            sum += exp_q[i].size();
        return sum;
    endfunction

    // two cycles high and two low keep edges on a line 4 cycles apart
    // an edge first sampled at k is stamped with the count at k+2
    task automatic pulse_lines(input logic [15:0] lines, output logic [63:0] stamp);
        stamp   = model_ts + 64'd2;
        lvds_in = lines;
        step();
        step();
        lvds_in = '0;
        step();
        step();
    endtask

    task automatic queue_enabled(input logic [15:0] lines, input logic [63:0] stamp);
        for (int ch = 0; ch < `QPIX_NUM_CH; ch++)
        begin
            if (lines[ch] && model_mask[ch])
                exp_q[ch].push_back(make_record(ch, stamp));
        end
    endtask

    // head of the FIFO through EV_HI then EV_LO where the second read pops
    task automatic pop_record();
        logic [31:0] hi;
        logic [31:0] lo;
        event_word_t got;
        int          ch;
        apb_read(`QPIX_REG_EV_HI, 1'b0, hi);
        apb_read(`QPIX_REG_EV_LO, 1'b0, lo);
        got.halves.hi = hi;
        got.halves.lo = lo;
        ch = int'(got.fields.ch);
        checks++;
        assert (exp_q[ch].size() != 0)
        else
        begin
            $display("Record from channel %0d at %0t ns had no hit expected", ch, $time);
            errors++;
        end
        if (exp_q[ch].size() != 0)
            check_value("event record", got, exp_q[ch].pop_front());
    endtask

    // pop until every expected record is out with a bound on idle polls
    task automatic drain_events();
        int          left;
        int          idle;
        logic [31:0] status;
        left = expected_total();
        idle = 0;
        while (left > 0 && idle < WAIT_LIMIT)
        begin
            apb_read(`QPIX_REG_STATUS, 1'b0, status);
            if (status[0])
                idle++;
            else
            begin
                pop_record();
                left--;
                idle = 0;
            end
        end
        if (left > 0)
            timeout_fail("draining the event FIFO");
    endtask

    task automatic check_drained();
        logic [31:0] status;
        // wait longer than the hit path so a stray record would show up
        for (int i = 0; i < 8; i++)
            step();
        apb_read(`QPIX_REG_STATUS, 1'b0, status);
        check_value("STATUS.empty", 64'(status[0]), 64'd1);
        checks++;
        assert (expected_total() == 0)
        else
        begin
            $display("Model queues still hold %0d records", expected_total());
            errors++;
        end
    endtask

    // FIFO fills with no reads and then one hit waits while the rest are lost
    task automatic hit_while_stalled(input int ch);
        logic [63:0] stamp;
        pulse_lines(16'h0001 << ch, stamp);
        if (stall_pending)
            model_lost++;
        else if (stall_fill < `QPIX_FIFO_DEPTH)
        begin
            stall_fill++;
            exp_q[ch].push_back(make_record(ch, stamp));
        end
        else
        begin
            stall_pending = 1'b1;
            exp_q[ch].push_back(make_record(ch, stamp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_reset_test();
        logic [31:0] rd;
        begin_test();
        check_value("trigger", 64'(trigger), 64'd0);
        apb_read(`QPIX_REG_STATUS, 1'b0, rd);
        check_value("STATUS.empty", 64'(rd[0]), 64'd1);
        check_value("STATUS.count", 64'(rd[12:8]), 64'd0);
        check_value("STATUS.lost", 64'(rd[31:16]), 64'd0);
        apb_read(`QPIX_REG_ID, 1'b0, rd);
        check_value("ID", 64'(rd), 64'(`QPIX_ID_VALUE));
        end_test("reset state");
    endtask

    task automatic run_hit_bursts(input string name, input int bursts,
                                  input logic [15:0] first_lines);
        logic [15:0] lines;
        logic [63:0] stamp;
        int          gap;
        for (int b = 0; b < bursts; b++)
        begin
            gap = $random(seed) & 3;
            for (int i = 0; i < gap; i++)
                step();
            lines = (b == 0) ? first_lines : 16'($random(seed));
            pulse_lines(lines, stamp);
            queue_enabled(lines, stamp);
            drain_events();
        end
        check_drained();
        end_test(name);
    endtask

    task automatic run_trigger_test();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] first_ts;
        int          n;
        int          high;
        begin_test();
        apb_write(`QPIX_REG_CTRL, {model_mask, 16'h0001}, 1'b0);
        n = 0;
        while (!trigger && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        if (!trigger)
            timeout_fail("waiting for trigger to rise");
        first_ts = model_ts;
        high = 0;
        n = 0;
        while (trigger && n < WAIT_LIMIT)
        begin
            high++;
            step();
            n++;
        end
        if (trigger)
            timeout_fail("waiting for trigger to fall");
        check_value("trigger high cycles", 64'(high), 64'(`QPIX_TRIG_CYCLES));
        apb_read(`QPIX_REG_TRIG_HI, 1'b0, hi);
        apb_read(`QPIX_REG_TRIG_LO, 1'b0, lo);
        check_value("TRIG_HI/TRIG_LO", {hi, lo}, first_ts);
        // strobe bit clears itself
        apb_read(`QPIX_REG_CTRL, 1'b0, lo);
        check_value("CTRL", 64'(lo), 64'({model_mask, 16'h0000}));
        end_test("trigger pulse");
    endtask

    task automatic run_overflow_test();
        logic [31:0] rd;
        int          ch;
        begin_test();
        ch = $random(seed) & 15;
        set_mask(16'h0001 << ch);
        stall_fill    = 0;
        stall_pending = 1'b0;
        for (int i = 0; i < 20; i++)
            hit_while_stalled(ch);
        for (int i = 0; i < 3; i++)
            hit_while_stalled(ch);
        apb_read(`QPIX_REG_STATUS, 1'b0, rd);
        check_value("STATUS.full", 64'(rd[1]), 64'd1);
        check_value("STATUS.count", 64'(rd[12:8]), 64'(`QPIX_FIFO_DEPTH));
        drain_events();
        apb_read(`QPIX_REG_STATUS, 1'b0, rd);
        check_value("STATUS.lost", 64'(rd[31:16]), 64'(model_lost));
        check_drained();
        end_test("overflow and lost hits");
    endtask

    task automatic run_bus_error_test();
        logic [31:0] rd;
        begin_test();
        apb_read(8'h1C, 1'b1, rd);
        apb_write(8'h40, 32'hFFFF_0001, 1'b1);
        apb_write(`QPIX_REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        step();
        step();
        // a rejected write must not start a pulse
        check_value("trigger", 64'(trigger), 64'd0);
        apb_read(`QPIX_REG_CTRL, 1'b0, rd);
        check_value("CTRL", 64'(rd), 64'({model_mask, 16'h0000}));
        // empty FIFO and the lost hits counted so far
        apb_read(`QPIX_REG_STATUS, 1'b0, rd);
        check_value("STATUS", 64'(rd), 64'({16'(model_lost), 16'h0001}));
        end_test("bus errors");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [15:0] mask;
        seed          = 6;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        test_errors   = 0;
        model_lost    = 0;
        model_mask    = '0;
        stall_fill    = 0;
        stall_pending = 1'b0;
        counter_reset = 1'b1;
        lvds_in       = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        // reset held over 5 rising edges
        repeat (5) @(posedge clk200);
        #2;
        counter_reset = 1'b0;

        run_reset_test();

        begin_test();
        set_mask(16'hFFFF);
        run_hit_bursts("random hits", 12, 16'($random(seed)));

        run_trigger_test();

        // first burst hits only the masked lines
        begin_test();
        mask = 16'($random(seed)) & 16'h7FFE;
        set_mask(mask);
        run_hit_bursts("masked channels", 8, ~mask);

        run_overflow_test();
        run_bus_error_test();
        end_run();
    end

endmodule

// File: include/qpix_cfg.svh
`ifndef QPIX_CFG_SVH
`define QPIX_CFG_SVH

// channel count and channel number width
`define QPIX_NUM_CH        16
`define QPIX_CH_W          4

// free-running counter and the part of it kept in a record
`define QPIX_TS_W          64
`define QPIX_EV_TS_W       60
`define QPIX_EV_W          64

// shared event memory
`define QPIX_FIFO_DEPTH    16
`define QPIX_FIFO_AW       4

// external trigger pulse length in clk200 cycles
`define QPIX_TRIG_CYCLES   8

// APB register map, byte offsets
`define QPIX_ADDR_W        8
`define QPIX_ID_VALUE      32'h5150_4958
`define QPIX_REG_CTRL      8'h00
`define QPIX_REG_STATUS    8'h04
`define QPIX_REG_TRIG_HI   8'h08
`define QPIX_REG_TRIG_LO   8'h0C
`define QPIX_REG_EV_HI     8'h10
`define QPIX_REG_EV_LO     8'h14
`define QPIX_REG_ID        8'h18

`endif

// File: logic/event_arbiter.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module event_arbiter
    import qpix_event_pkg::*;
(
    input  logic                    clk200,
    input  logic                    counter_reset,
    input  logic [`QPIX_NUM_CH-1:0] pending,
    input  event_word_t             records [`QPIX_NUM_CH],
    input  logic                    full,
    output logic [`QPIX_NUM_CH-1:0] grant,
    output logic                    wr_en,
    output event_word_t             wr_data
);

    logic [`QPIX_CH_W-1:0]   rr_ptr;
    logic [`QPIX_CH_W-1:0]   sel_idx;
    logic [`QPIX_CH_W-1:0]   probe;
    logic                    found;
    logic                    issue;
    logic [`QPIX_NUM_CH-1:0] one_hot;

    ////////////////////////////////////////////////////////////////////////////
    // round-robin search
    ////////////////////////////////////////////////////////////////////////////

    // first pending channel at or after the pointer with wrap-around
    always_comb
    begin
        found   = 1'b0;
        sel_idx = rr_ptr;
        probe   = rr_ptr;
        for (int i = 0; i < `QPIX_NUM_CH; i++)
        begin
            probe = rr_ptr + i[`QPIX_CH_W-1:0];
            if (!found && pending[probe])
            begin
                found   = 1'b1;
                sel_idx = probe;
            end
        end
    end

    // a write in flight is not yet counted in full
    // so at most one grant every other cycle
    assign issue   = found & ~full & ~wr_en;
    assign one_hot = {{(`QPIX_NUM_CH-1){1'b0}}, 1'b1} << sel_idx;
    assign grant   = issue ? one_hot : '0;

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            rr_ptr <= '0;
            wr_en  <= 1'b0;
        end
        else
        begin
            wr_en <= issue;
            // next search starts just past the winner
            if (issue)
                rr_ptr <= sel_idx + 1'b1;
        end
    end

    // registered write into the shared FIFO
    always_ff @(posedge clk200)
    begin
        if (issue)
            wr_data <= records[sel_idx];
    end

    // channels keep their hit until the arbiter grants it
    a_pending_held: assert property (@(posedge clk200) disable iff (counter_reset)
        ($past(pending) & ~pending & ~$past(grant)) == '0);

endmodule

// File: logic/event_fifo.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module event_fifo
    import qpix_event_pkg::*;
(
    input  logic                   clk200,
    input  logic                   counter_reset,
    input  logic                   wr_en,
    input  event_word_t            wr_data,
    input  logic                   rd_en,
    output event_word_t            rd_data,
    output logic                   empty,
    output logic                   full,
    output logic [`QPIX_FIFO_AW:0] count
);

    event_word_t               mem [`QPIX_FIFO_DEPTH];
    logic [`QPIX_FIFO_AW-1:0]  wr_ptr;
    logic [`QPIX_FIFO_AW-1:0]  rd_ptr;

    // event storage
    always_ff @(posedge clk200)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            // occupancy follows the net change
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
        end
    end

    // head shows without latency
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == `QPIX_FIFO_DEPTH);

    // arbiter and register side must both honour the flags
    a_no_overflow: assert property (@(posedge clk200) disable iff (counter_reset)
        full |-> !wr_en);
    a_no_underflow: assert property (@(posedge clk200) disable iff (counter_reset)
        empty |-> !rd_en);

endmodule

// File: logic/hit_channel.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module hit_channel
    import qpix_event_pkg::*;
(
    input  logic                  clk200,
    input  logic                  counter_reset,
    input  logic                  lvds,
    input  logic                  enable,
    input  logic [`QPIX_CH_W-1:0] ch_id,
    input  logic [`QPIX_TS_W-1:0] timestamp,
    input  logic                  grant,
    output logic                  pending,
    output event_word_t           record,
    output logic                  lost
);

    logic sync1;
    logic sync2;
    logic sync3;
    logic rise;
    logic accept;

    // two flops into clk200 and a third that holds the previous level
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
            sync3 <= 1'b0;
        end
        else
        begin
            sync1 <= lvds;
            sync2 <= sync1;
            sync3 <= sync2;
        end
    end

    // masked channels see no edges at all
    assign rise = sync2 & ~sync3 & enable;

    // slot is free when idle or when the current hit leaves this cycle
    assign accept = rise & (~pending | grant);
    assign lost   = rise & pending & ~grant;

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            pending <= 1'b0;
        else if (accept)
            pending <= 1'b1;
        else if (grant)
            pending <= 1'b0;
    end

    // stamp with the counter seen on the accepting edge
    always_ff @(posedge clk200)
    begin
        if (accept)
        begin
            record.fields.ch <= ch_id;
            record.fields.ts <= timestamp[`QPIX_EV_TS_W-1:0];
        end
    end

    // the arbiter only grants a channel that holds a hit
    a_grant_held: assert property (@(posedge clk200) disable iff (counter_reset)
        grant |-> pending);

endmodule

// File: logic/qpix_apb_regs.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module qpix_apb_regs
    import qpix_event_pkg::*;
(
    input  logic                    clk200,
    input  logic                    counter_reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`QPIX_ADDR_W-1:0] paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    empty,
    input  logic                    full,
    input  logic [`QPIX_FIFO_AW:0]  count,
    input  event_word_t             rd_data,
    input  logic [`QPIX_TS_W-1:0]   trig_ts,
    input  logic                    trig_busy,
    input  logic [`QPIX_NUM_CH-1:0] lost,
    output logic [`QPIX_NUM_CH-1:0] enable_mask,
    output logic                    trig_start,
    output logic                    rd_en
);

    logic        access;
    logic        mapped;
    logic        read_only;
    logic        ctrl_wr;
    logic [31:0] rd_word;
    logic [4:0]  lost_add;
    logic [16:0] lost_sum;
    logic [15:0] lost_cnt;

    // no wait states, every access phase completes
    assign pready = 1'b1;
    assign access = psel & penable;

    ////////////////////////////////////////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        mapped    = 1'b1;
        read_only = 1'b1;
        rd_word   = '0;
        case (paddr)
            `QPIX_REG_CTRL:
            begin
                read_only = 1'b0;
                // strobe bit always reads back zero
                rd_word   = {enable_mask, 16'h0000};
            end
            `QPIX_REG_STATUS:
                rd_word = {lost_cnt, 3'b000, count, 6'b000000, full, empty};
            `QPIX_REG_TRIG_HI:
                rd_word = trig_ts[63:32];
            `QPIX_REG_TRIG_LO:
                rd_word = trig_ts[31:0];
            // event head through the bus view, zero when nothing is held
            `QPIX_REG_EV_HI:
                rd_word = empty ? 32'h0 : rd_data.halves.hi;
            `QPIX_REG_EV_LO:
                rd_word = empty ? 32'h0 : rd_data.halves.lo;
            `QPIX_REG_ID:
                rd_word = `QPIX_ID_VALUE;
            default:
                mapped = 1'b0;
        endcase
    end

    assign prdata  = rd_word;
    assign pslverr = access & (~mapped | (pwrite & read_only));

    // pop lands on the edge that ends the EV_LO read
    assign rd_en   = access & ~pwrite & (paddr == `QPIX_REG_EV_LO) & ~empty;

    ////////////////////////////////////////////////////////////////////////////
    // control register
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl_wr = access & pwrite & (paddr == `QPIX_REG_CTRL);

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            enable_mask <= '0;
            trig_start  <= 1'b0;
        end
        else
        begin
            // one-cycle strobe, nothing to start while a pulse runs
            trig_start <= ctrl_wr & pwdata[0] & ~trig_busy;
            if (ctrl_wr)
                enable_mask <= pwdata[31:16];
        end
    end

    // several channels may lose a hit in the same cycle
    always_comb
    begin
        lost_add = '0;
        for (int i = 0; i < `QPIX_NUM_CH; i++)
            lost_add = lost_add + {4'b0000, lost[i]};
    end

    assign lost_sum = {1'b0, lost_cnt} + {12'h000, lost_add};

    // saturating lost-hit count
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            lost_cnt <= '0;
        else if (lost_sum[16])
            lost_cnt <= 16'hFFFF;
        else
            lost_cnt <= lost_sum[15:0];
    end

    a_apb_phase: assert property (@(posedge clk200) disable iff (counter_reset)
        penable |-> psel);

endmodule

// File: logic/qpix_daq_top.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module qpix_daq_top
    import qpix_event_pkg::*;
(
    input  logic                    clk200,
    input  logic                    counter_reset,
    input  logic [`QPIX_NUM_CH-1:0] lvds_in,
    output logic                    trigger,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`QPIX_ADDR_W-1:0] paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);

    logic [`QPIX_TS_W-1:0]   timestamp;
    logic [`QPIX_TS_W-1:0]   trig_ts;
    logic                    trig_busy;
    logic                    trig_start;
    logic [`QPIX_NUM_CH-1:0] enable_mask;
    logic [`QPIX_NUM_CH-1:0] ch_pending;
    logic [`QPIX_NUM_CH-1:0] ch_grant;
    logic [`QPIX_NUM_CH-1:0] ch_lost;
    event_word_t             ch_record [`QPIX_NUM_CH];
    logic                    wr_en;
    event_word_t             wr_data;
    logic                    rd_en;
    event_word_t             rd_data;
    logic                    empty;
    logic                    full;
    logic [`QPIX_FIFO_AW:0]  count;

    ////////////////////////////////////////////////////////////////////////////
    // hit inputs
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `QPIX_NUM_CH; i++)
    begin : g_ch
        // channel number fixed per instance
        localparam logic [`QPIX_CH_W-1:0] CH_NUM = i;

        hit_channel u_ch (
            .clk200        (clk200),
            .counter_reset (counter_reset),
            .lvds          (lvds_in[i]),
            .enable        (enable_mask[i]),
            .ch_id         (CH_NUM),
            .timestamp     (timestamp),
            .grant         (ch_grant[i]),
            .pending       (ch_pending[i]),
            .record        (ch_record[i]),
            .lost          (ch_lost[i])
        );
    end

    // sixteen channels share one event memory
    event_arbiter u_arb (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .pending       (ch_pending),
        .records       (ch_record),
        .full          (full),
        .grant         (ch_grant),
        .wr_en         (wr_en),
        .wr_data       (wr_data)
    );

    event_fifo u_fifo (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .empty         (empty),
        .full          (full),
        .count         (count)
    );

    trigger_timer u_timer (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .trig_start    (trig_start),
        .timestamp     (timestamp),
        .trig_ts       (trig_ts),
        .trigger       (trigger),
        .trig_busy     (trig_busy)
    );

    qpix_apb_regs u_regs (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .empty         (empty),
        .full          (full),
        .count         (count),
        .rd_data       (rd_data),
        .trig_ts       (trig_ts),
        .trig_busy     (trig_busy),
        .lost          (ch_lost),
        .enable_mask   (enable_mask),
        .trig_start    (trig_start),
        .rd_en         (rd_en)
    );

endmodule

// File: logic/qpix_event_pkg.sv
`include "qpix_cfg.svh"

package qpix_event_pkg;

    // record as the hit path builds it
    // channel number on top, truncated timestamp below
    typedef struct packed {
        logic [`QPIX_CH_W-1:0]    ch;
        logic [`QPIX_EV_TS_W-1:0] ts;
    } event_fields_t;

    // record as the APB side reads it, two 32-bit words
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } event_halves_t;

    // one 64-bit event word, two views of the same bits
    typedef union packed {
        event_fields_t fields;
        event_halves_t halves;
    } event_word_t;

endpackage

// File: logic/trigger_timer.sv
`timescale 1ns/1ps
`include "qpix_cfg.svh"

module trigger_timer (
    input  logic                  clk200,
    input  logic                  counter_reset,
    input  logic                  trig_start,
    output logic [`QPIX_TS_W-1:0] timestamp,
    output logic [`QPIX_TS_W-1:0] trig_ts,
    output logic                  trigger,
    output logic                  trig_busy
);

    localparam int LEN_W = $clog2(`QPIX_TRIG_CYCLES);

    logic [LEN_W-1:0] cycles_left;

    // free-running time base, zero in the first cycle out of reset
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // trigger pulse
    ////////////////////////////////////////////////////////////////////////////

    // strobes during a pulse are dropped
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            trigger     <= 1'b0;
            cycles_left <= '0;
            trig_ts     <= '0;
        end
        else if (trigger)
        begin
            if (cycles_left == '0)
                trigger <= 1'b0;
            else
                cycles_left <= cycles_left - 1'b1;
        end
        else if (trig_start)
        begin
            trigger     <= 1'b1;
            cycles_left <= LEN_W'(`QPIX_TRIG_CYCLES - 1);
            // counter value of the first high cycle
            trig_ts     <= timestamp + 1'b1;
        end
    end

    assign trig_busy = trigger;

endmodule

// File: tb.f
+incdir+include
logic/qpix_event_pkg.sv
logic/hit_channel.sv
logic/event_arbiter.sv
logic/event_fifo.sv
logic/trigger_timer.sv
logic/qpix_apb_regs.sv
logic/qpix_daq_top.sv
bench/tb_qpix_daq.sv
